// ==== src.f ====
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_bus_ctrl.sv
design/rv_cpu.sv
bench/tb_cpu.sv

// ==== bench/cpu_tests.txt ====
# P byte_addr word | S word_addr sel data_on_written_lanes | E halted fault instr_count
# All numbers are hex. x1 holds the data base 0x200
P 000 20000093
P 004 80000137
P 008 ffd00193
P 00c 40415213
P 010 0040a023
P 014 402182b3
P 018 01c15313
P 01c 006193b3
P 020 0072c2b3
P 024 0050a223
P 028 00312433
P 02c 0021b4b3
P 030 00808423
P 034 009084a3
P 038 12345517
P 03c 7c056513
P 040 406155b3
P 044 00b56533
P 048 00a0a623
# Loads of the word ffb457f8 at 0x20c, each result stored with sw
P 04c 00c08603
P 050 00c0a823
P 054 00d08603
P 058 00c0aa23
P 05c 00e08603
P 060 00c0ac23
P 064 00f08603
P 068 00c0ae23
P 06c 00c0c603
P 070 02c0a023
P 074 00d0c603
P 078 02c0a223
P 07c 00e0c603
P 080 02c0a423
P 084 00f0c603
P 088 02c0a623
P 08c 00c09603
P 090 02c0a823
P 094 00e09603
P 098 02c0aa23
P 09c 00c0d603
P 0a0 02c0ac23
P 0a4 00e0d603
P 0a8 02c0ae23
P 0ac 00c0a603
P 0b0 04c0a023
# Taken branches skip a bad store, untaken ones would jump to the trap at 0x10c
P 0b4 00630463
P 0b8 0630a423
P 0bc 04631863
P 0c0 00311463
P 0c4 0630a423
P 0c8 04310263
P 0cc 00314463
P 0d0 0630a423
P 0d4 02315c63
P 0d8 0021d463
P 0dc 0630a423
P 0e0 0221c663
P 0e4 00316463
P 0e8 0630a423
P 0ec 0221e063
P 0f0 0021f463
P 0f4 0630a423
P 0f8 00317a63
P 0fc 0460a223
P 100 01400a6f
P 104 0550a623
P 108 00000073
P 10c 0630a223
P 110 00000073
P 114 0540a423
P 118 001a0ae7
S 200 f f8000000
S 204 f 800002fd
S 208 1 00000001
S 208 2 00000000
S 20c f ffb457f8
S 210 f fffffff8
S 214 f 00000057
S 218 f ffffffb4
S 21c f ffffffff
S 220 f 000000f8
S 224 f 00000057
S 228 f 000000b4
S 22c f 000000ff
S 230 f 000057f8
S 234 f ffffffb4
S 238 f 000057f8
S 23c f 0000ffb4
S 240 f ffb457f8
S 244 f 00000008
S 248 f 00000104
S 24c f 0000011c
E 1 0 3f

// ==== bench/tb_cpu.sv ====
/*
 Testbench for the RV32I core. It models a 1 KB Wishbone memory with 1 to 4 cycle
 random wait states and checks every store in order against bench/cpu_tests.txt.
 Program and data must fit below byte address 0x400.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;

	localparam int MEM_WORDS  = 256;
	localparam int MAX_STORES = 64;
	localparam int WORST_WAIT = 4;

	logic        instr;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        halted;
	logic        fault;

	logic [31:0] mem [0:MEM_WORDS-1];
	logic [31:0] exp_adr [0:MAX_STORES-1];
	logic [3:0]  exp_sel [0:MAX_STORES-1];
	logic [31:0] exp_dat [0:MAX_STORES-1];
	int          exp_stores = 0;
	int          stores_seen = 0;
	logic        exp_halted = 1'b1;
	logic        exp_fault = 1'b0;
	logic [31:0] exp_count = '0;
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 0;
	logic        file_ok;

	// State of the memory model between clock edges
	logic [31:0] rng = 32'ha6bb802e;
	logic        pending;
	int          wait_left;
	logic [31:0] req_adr;
	logic [3:0]  req_sel;
	logic        req_we;
	logic [31:0] req_dat;

	rv_cpu #(
		.RESET_PC(32'h0000_0000)
	) DUT (
		.instr   (instr),
		.reset   (reset),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.wb_sel  (wb_sel),
		.wb_adr  (wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack  (wb_ack),
		.halted  (halted),
		.fault   (fault)
	);

	initial begin
		instr = 1'b0;
		forever #10 instr = ~instr;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] sel);
		logic [31:0] m;
		for (int i = 0; i < 4; i++) begin
			m[8 * i +: 8] = {8{sel[i]}};
		end
		return m;
	endfunction

	// Record types: P loads memory, S appends an expected store, E gives the end state
	task automatic load_tests(output logic ok);
		int               fd;
		int               code;
		logic [7:0]       tag;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [8*128-1:0] rest;
		logic             more;
		fd = $fopen("bench/cpu_tests.txt", "r");
		ok = (fd != 0);
		more = ok;
		while (more) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				more = 1'b0;
			end else if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "P") begin
				code = $fscanf(fd, "%h %h", a, b);
				mem[a[9:2]] = b;
			end else if (tag == "S" && exp_stores < MAX_STORES) begin
				code = $fscanf(fd, "%h %h %h", a, b, c);
				exp_adr[exp_stores] = a;
				exp_sel[exp_stores] = b[3:0];
				exp_dat[exp_stores] = c;
				exp_stores++;
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h %h", a, b, c);
				exp_halted = a[0];
				exp_fault = b[0];
				exp_count = c;
			end else begin
				errors++;
				$display("test file record of type %c could not be used", tag);
				code = $fgets(rest, fd);
			end
		end
		if (ok) begin
			$fclose(fd);
		end
	endtask

	task automatic check_store();
		logic [31:0] mask;
		mask = lane_mask(wb_sel);
		assert (stores_seen < exp_stores) else begin
			errors++;
			$display("unexpected store at %0t to address %h with sel %b and data %h",
				$time, wb_adr, wb_sel, wb_dat_w);
		end
		if (stores_seen < exp_stores) begin
			assert (wb_adr == exp_adr[stores_seen] && wb_sel == exp_sel[stores_seen] &&
				(wb_dat_w & mask) == (exp_dat[stores_seen] & mask)) else begin
				errors++;
				$display("mismatch at %0t: store %0d adr %h sel %b data %h, expected %h %b %h",
					$time, stores_seen, wb_adr, wb_sel, wb_dat_w & mask,
					exp_adr[stores_seen], exp_sel[stores_seen], exp_dat[stores_seen]);
			end
		end
		stores_seen++;
	endtask

	task automatic complete_access();
		logic [7:0] idx;
		idx = wb_adr[9:2];
		assert (wb_adr < MEM_WORDS * 4) else begin
			errors++;
			$display("access at %0t to address %h lies outside the memory model", $time, wb_adr);
		end
		if (wb_we) begin
			check_store();
			for (int i = 0; i < 4; i++) begin
				if (wb_sel[i]) begin
					mem[idx][8 * i +: 8] = wb_dat_w[8 * i +: 8];
				end
			end
		end else begin
			wb_dat_r = mem[idx];
		end
	endtask

	// One call per falling edge; ack stays high for exactly one rising edge
	task automatic serve_bus();
		if (reset) begin
			wb_ack = 1'b0;
			pending = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!pending) begin
				pending = 1'b1;
				req_adr = wb_adr;
				req_sel = wb_sel;
				req_we = wb_we;
				req_dat = wb_dat_w;
				rng = xorshift(rng);
				wait_left = 1 + int'(rng % WORST_WAIT);
			end else begin
				assert (wb_adr == req_adr && wb_sel == req_sel && wb_we == req_we &&
					wb_dat_w == req_dat) else begin
					errors++;
					$display("mismatch at %0t: request changed in a wait state, adr %h sel %b we %b",
						$time, wb_adr, wb_sel, wb_we);
				end
			end
			wait_left--;
			if (wait_left == 0) begin
				complete_access();
				pending = 1'b0;
				wb_ack = 1'b1;
			end
		end
	endtask

	initial begin
		wb_ack = 1'b0;
		wb_dat_r = '0;
		pending = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge instr);
			serve_bus();
		end
	end

	task automatic check_quiet_bus();
		repeat (20) begin
			@(negedge instr);
			assert (!wb_cyc && !wb_stb) else begin
				errors++;
				$display("bus request at %0t after the core halted", $time);
			end
		end
	endtask

	// Each instruction costs at most one fetch and one data access
	initial begin
		wait (cycle_limit > 0);
		while (cycles <= cycle_limit) begin
			@(posedge instr);
			if (!reset && !halted) begin
				cycles++;
			end
		end
		$display("timeout: the core did not halt within %0d cycles", cycle_limit);
		$display("stores %0d of %0d, errors %0d", stores_seen, exp_stores, errors);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
		load_tests(file_ok);
		if (!file_ok) begin
			$display("the test file bench/cpu_tests.txt could not be opened");
			$display("Simulation FAILED");
			$finish;
		end else begin
			cycle_limit = exp_count * 2 * (WORST_WAIT + 2) + 50;
			repeat (8) @(negedge instr);
			reset = 1'b0;
			while (!halted) begin
				@(negedge instr);
			end
			check_quiet_bus();
			assert (halted == exp_halted && fault == exp_fault) else begin
				errors++;
				$display("mismatch at %0t: halted %b fault %b, expected %b %b",
					$time, halted, fault, exp_halted, exp_fault);
			end
			assert (stores_seen == exp_stores) else begin
				errors++;
				$display("mismatch at %0t: %0d stores seen, %0d expected",
					$time, stores_seen, exp_stores);
			end
			$display("stores %0d of %0d, errors %0d", stores_seen, exp_stores, errors);
			if (errors == 0) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_cpu.sv ====
/*
 RV32I multi-cycle core with one Wishbone classic master for code and data.
 RESET_PC must be word aligned. halted goes high on ECALL, EBREAK or an
 illegal instruction, and fault marks the illegal case.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_cpu import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic       instr,
	input  logic       reset,
	output logic       wb_cyc,
	output logic       wb_stb,
	output logic       wb_we,
	output logic [3:0] wb_sel,
	output word_t      wb_adr,
	output word_t      wb_dat_w,
	input  word_t      wb_dat_r,
	input  logic       wb_ack,
	output logic       halted,
	output logic       fault
);

	decoded_t dec;
	exec_t    ex;
	word_t    instr_word;
	word_t    pc;
	word_t    load_word;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    rd_data;
	logic     rd_we;

	rv_bus_ctrl #(
		.RESET_PC(RESET_PC)
	) u_bus_ctrl (
		.instr     (instr),
		.reset     (reset),
		.dec       (dec),
		.ex        (ex),
		.instr_word(instr_word),
		.pc        (pc),
		.rd_we     (rd_we),
		.load_word (load_word),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_sel    (wb_sel),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.halted    (halted),
		.fault     (fault)
	);

	rv_decode u_decode (
		.instr_word(instr_word),
		.dec       (dec)
	);

	rv_regfile u_regfile (
		.instr  (instr),
		.reset  (reset),
		.rs1    (dec.rs1),
		.rs2    (dec.rs2),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.rd     (dec.rd),
		.rd_data(rd_data),
		.rd_we  (rd_we)
	);

	rv_execute u_execute (
		.dec    (dec),
		.pc     (pc),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.ex     (ex)
	);

	rv_result u_result (
		.dec      (dec),
		.ex       (ex),
		.pc       (pc),
		.load_word(load_word),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

// ==== design/rv_bus_ctrl.sv ====
/*
 Sequencer FSM: owns the PC and the single Wishbone classic master port.
 One access at a time. cyc and stb drop for at least one cycle after every ack.
 Data accesses drive the word address on wb_adr and mark lanes with wb_sel.
 S_HALT is left only by reset.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_bus_ctrl import rv_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic       instr,
	input  logic       reset,
	input  decoded_t   dec,
	input  exec_t      ex,
	output word_t      instr_word,
	output word_t      pc,
	output logic       rd_we,
	output word_t      load_word,
	output logic       wb_cyc,
	output logic       wb_stb,
	output logic       wb_we,
	output logic [3:0] wb_sel,
	output word_t      wb_adr,
	output word_t      wb_dat_w,
	input  word_t      wb_dat_r,
	input  logic       wb_ack,
	output logic       halted,
	output logic       fault
);

	bus_state_e state;
	logic       fetch_start;
	logic       fetch_done;
	logic       mem_start;
	logic       stop;

	assign fetch_start = (state == S_FETCH) && !wb_cyc;
	assign fetch_done = (state == S_FETCH) && wb_cyc && wb_ack;
	assign stop = dec.is_halt || dec.is_illegal;
	assign mem_start = (state == S_EXEC) && !stop && (dec.is_load || dec.is_store);

	always_ff @(posedge instr) begin
		if (reset) begin
			state <= S_FETCH;
			pc <= RESET_PC;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
			halted <= 1'b0;
			fault <= 1'b0;
		end else begin
			case (state)
				S_FETCH: begin
					if (fetch_start) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= 1'b0;
					end else if (fetch_done) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (stop) begin
						halted <= 1'b1;
						fault <= dec.is_illegal;
						state <= S_HALT;
					end else if (mem_start) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= dec.is_store;
						state <= S_MEM;
					end else begin
						// Non-memory instructions commit here
						pc <= ex.next_pc;
						state <= S_FETCH;
					end
				end
				S_MEM: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we <= 1'b0;
						pc <= ex.next_pc;
						state <= S_FETCH;
					end
				end
				default: state <= S_HALT;
			endcase
		end
	end

	// Request payload is loaded only when a cycle opens, so it holds through wait states
	always_ff @(posedge instr) begin
		if (fetch_start) begin
			wb_adr <= pc;
			wb_sel <= 4'b1111;
		end else if (mem_start) begin
			wb_adr <= {ex.mem_addr[31:2], 2'b00};
			wb_sel <= ex.store_sel;
			wb_dat_w <= ex.store_data;
		end
		if (fetch_done) begin
			instr_word <= wb_dat_r;
		end
	end

	// Loads write back straight from the bus in the ack cycle
	assign load_word = wb_dat_r;

	always_comb begin
		case (state)
			S_EXEC:  rd_we = dec.reg_write && !dec.is_load;
			S_MEM:   rd_we = wb_ack && dec.is_load && dec.reg_write;
			default: rd_we = 1'b0;
		endcase
	end

	// A request is open only in the fetch and data states and always inside a cycle
	a_stb_needs_cyc: assert property (@(posedge instr) disable iff (reset)
		wb_stb |-> wb_cyc && (state == S_FETCH || state == S_MEM));

	// Data accesses must be naturally aligned to their size
	a_mem_aligned: assert property (@(posedge instr) disable iff (reset)
		state == S_MEM |-> !(dec.funct3[1] && ex.mem_addr[1:0] != 2'b00) &&
			!(dec.funct3[0] && ex.mem_addr[0]));

endmodule

`default_nettype wire

// ==== design/rv_result.sv ====
/*
 Writeback data selection.
 load_word is the raw bus word with lanes in place, so the low address bits pick
 the byte or halfword. Misaligned accesses are not handled.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_result import rv_pkg::*; (
	input  decoded_t dec,
	input  exec_t    ex,
	input  word_t    pc,
	input  word_t    load_word,
	output word_t    rd_data
);

	logic [7:0]  byte_lane;
	logic [15:0] half_lane;
	word_t       load_val;

	assign byte_lane = load_word[8 * ex.mem_addr[1:0] +: 8];
	assign half_lane = ex.mem_addr[1] ? load_word[31:16] : load_word[15:0];

	// funct3[2] set means zero extension (LBU, LHU)
	always_comb begin
		case (dec.funct3)
			3'b000:  load_val = {{24{byte_lane[7]}}, byte_lane};
			3'b001:  load_val = {{16{half_lane[15]}}, half_lane};
			3'b100:  load_val = {24'b0, byte_lane};
			3'b101:  load_val = {16'b0, half_lane};
			default: load_val = load_word;
		endcase
	end

	always_comb begin
		case (dec.wb_src)
			WB_LOAD: rd_data = load_val;
			// Link address for JAL and JALR
			WB_PC4:  rd_data = pc + 32'd4;
			default: rd_data = ex.alu_out;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
/*
 Combinational execute stage: ALU, branch compare, next PC, data address.
 Store data is replicated over all lanes and store_sel marks the written ones.
 The same sel pattern serves loads. Alignment is not checked here.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_execute import rv_pkg::*; (
	input  decoded_t dec,
	input  word_t    pc,
	input  word_t    rs1_val,
	input  word_t    rs2_val,
	output exec_t    ex
);

	word_t op_a;
	word_t op_b;
	word_t addr_sum;
	word_t pc_plus4;
	word_t pc_target;
	logic  taken;

	assign op_a = dec.a_is_pc ? pc : rs1_val;
	assign op_b = dec.b_is_imm ? dec.imm : rs2_val;

	// One adder serves loads, stores and the JALR target
	assign addr_sum = rs1_val + dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign pc_target = pc + dec.imm;

	always_comb begin
		case (dec.alu_op)
			ALU_ADD:    ex.alu_out = op_a + op_b;
			ALU_SUB:    ex.alu_out = op_a - op_b;
			ALU_SLL:    ex.alu_out = op_a << op_b[4:0];
			ALU_SLT:    ex.alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   ex.alu_out = {31'b0, op_a < op_b};
			ALU_XOR:    ex.alu_out = op_a ^ op_b;
			ALU_SRL:    ex.alu_out = op_a >> op_b[4:0];
			ALU_SRA:    ex.alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_OR:     ex.alu_out = op_a | op_b;
			ALU_AND:    ex.alu_out = op_a & op_b;
			ALU_PASS_B: ex.alu_out = op_b;
			default:    ex.alu_out = '0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000:  taken = (rs1_val == rs2_val);
			3'b001:  taken = (rs1_val != rs2_val);
			3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
			3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
			3'b110:  taken = (rs1_val < rs2_val);
			3'b111:  taken = (rs1_val >= rs2_val);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (dec.is_jalr) begin
			ex.next_pc = {addr_sum[31:1], 1'b0};
		end else if (dec.is_jal || (dec.is_branch && taken)) begin
			ex.next_pc = pc_target;
		end else begin
			ex.next_pc = pc_plus4;
		end
	end

	assign ex.mem_addr = addr_sum;

	// funct3[1:0] gives the access size for loads and stores alike
	always_comb begin
		case (dec.funct3[1:0])
			2'b00: begin
				ex.store_data = {4{rs2_val[7:0]}};
				ex.store_sel = 4'b0001 << addr_sum[1:0];
			end
			2'b01: begin
				ex.store_data = {2{rs2_val[15:0]}};
				ex.store_sel = addr_sum[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				ex.store_data = rs2_val;
				ex.store_sel = 4'b1111;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
/*
 Register file with x1..x31 writable and x0 hard-wired to zero.
 Reads are combinational, writes land on the rising edge.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input  logic     instr,
	input  logic     reset,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    rs1_val,
	output word_t    rs2_val,
	input  reg_idx_t rd,
	input  word_t    rd_data,
	input  logic     rd_we
);

	word_t regs [1:31];

	always_ff @(posedge instr) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd != '0) begin
			regs[rd] <= rd_data;
		end
	end

	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	// The sequencer must be idle once reset has held for a cycle
	a_no_write_in_reset: assert property (@(posedge instr)
		reset && $past(reset) |-> !rd_we);

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
/*
 Combinational RV32I decoder.
 ECALL and EBREAK both halt. FENCE decodes to a no-op.
 Unknown opcodes and bad funct3/funct7 pairs flag is_illegal and clear all side effects.
*/
`timescale 1ns/100ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input  word_t    instr_word,
	output decoded_t dec
);

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	alu_op_t    alu_fn;
	logic       reg_form;
	logic       shift_op;
	logic       alt_ok;
	logic       funct_bad;

	assign opcode = instr_word[6:0];
	assign funct3 = instr_word[14:12];
	assign funct7 = instr_word[31:25];

	// Immediate formats, all sign-extended from bit 31
	assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
	assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
	assign imm_b = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
		instr_word[30:25], instr_word[11:8], 1'b0};
	assign imm_u = {instr_word[31:12], 12'b0};
	assign imm_j = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
		instr_word[20], instr_word[30:21], 1'b0};

	assign reg_form = (opcode == OP_REG);
	assign shift_op = (funct3[1:0] == 2'b01);

	// Bit 30 selects SUB and SRA, and is only legal on those two encodings
	assign alt_ok = (funct3 == 3'b101) || (funct3 == 3'b000 && reg_form);
	assign funct_bad = (reg_form || shift_op) &&
		!(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && alt_ok));

	// OP and OP-IMM share one funct3 map
	always_comb begin
		case (funct3)
			3'b000:  alu_fn = (reg_form && funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  alu_fn = ALU_SLL;
			3'b010:  alu_fn = ALU_SLT;
			3'b011:  alu_fn = ALU_SLTU;
			3'b100:  alu_fn = ALU_XOR;
			3'b101:  alu_fn = funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  alu_fn = ALU_OR;
			default: alu_fn = ALU_AND;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.rs1 = instr_word[19:15];
		dec.rs2 = instr_word[24:20];
		dec.rd = instr_word[11:7];
		dec.funct3 = funct3;
		dec.alu_op = ALU_ADD;
		dec.wb_src = WB_ALU;
		case (opcode)
			OP_LUI: begin
				dec.imm = imm_u;
				dec.b_is_imm = 1'b1;
				dec.alu_op = ALU_PASS_B;
				dec.reg_write = 1'b1;
			end
			OP_AUIPC: begin
				dec.imm = imm_u;
				dec.a_is_pc = 1'b1;
				dec.b_is_imm = 1'b1;
				dec.reg_write = 1'b1;
			end
			OP_JAL: begin
				dec.imm = imm_j;
				dec.is_jal = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_src = WB_PC4;
			end
			OP_JALR: begin
				dec.imm = imm_i;
				dec.is_jalr = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_src = WB_PC4;
				dec.is_illegal = (funct3 != 3'b000);
			end
			OP_BRANCH: begin
				dec.imm = imm_b;
				dec.is_branch = 1'b1;
				// funct3 010 and 011 are not branch encodings
				dec.is_illegal = (funct3[2:1] == 2'b01);
			end
			OP_LOAD: begin
				dec.imm = imm_i;
				dec.b_is_imm = 1'b1;
				dec.is_load = 1'b1;
				dec.reg_write = 1'b1;
				dec.wb_src = WB_LOAD;
				dec.is_illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			OP_STORE: begin
				dec.imm = imm_s;
				dec.b_is_imm = 1'b1;
				dec.is_store = 1'b1;
				dec.is_illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			OP_IMM: begin
				dec.imm = imm_i;
				dec.b_is_imm = 1'b1;
				dec.alu_op = alu_fn;
				dec.reg_write = 1'b1;
				dec.is_illegal = funct_bad;
			end
			OP_REG: begin
				dec.alu_op = alu_fn;
				dec.reg_write = 1'b1;
				dec.is_illegal = funct_bad;
			end
			// A single in-order core has nothing to order
			OP_FENCE: dec.reg_write = 1'b0;
			OP_SYSTEM: dec.is_halt = 1'b1;
			default: dec.is_illegal = 1'b1;
		endcase

		// An illegal word must not touch registers, memory or the PC
		if (dec.is_illegal) begin
			dec.reg_write = 1'b0;
			dec.is_load = 1'b0;
			dec.is_store = 1'b0;
			dec.is_branch = 1'b0;
			dec.is_jal = 1'b0;
			dec.is_jalr = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
/*
 Shared types for the RV32I multi-cycle core.
 Opcode and ALU codes are plain vector constants. Only the sequencer FSM uses an enum.
*/
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [1:0]  wb_src_t;

	// Major opcodes of the RV32I base set
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_FENCE  = 7'b0001111;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;

	localparam wb_src_t WB_ALU  = 2'd0;
	localparam wb_src_t WB_LOAD = 2'd1;
	localparam wb_src_t WB_PC4  = 2'd2;

	// Everything the datapath needs to know about one instruction
	typedef struct packed {
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		reg_idx_t   rd;
		word_t      imm;
		alu_op_t    alu_op;
		logic       a_is_pc;
		logic       b_is_imm;
		logic [2:0] funct3;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic       is_load;
		logic       is_store;
		logic       reg_write;
		wb_src_t    wb_src;
		logic       is_halt;
		logic       is_illegal;
	} decoded_t;

	typedef struct packed {
		word_t      alu_out;
		word_t      next_pc;
		word_t      mem_addr;
		word_t      store_data;
		logic [3:0] store_sel;
	} exec_t;

	typedef enum logic [1:0] {
		S_FETCH,
		S_EXEC,
		S_MEM,
		S_HALT
	} bus_state_e;

endpackage

`default_nettype wire
